// ==== Bender.yml ====
package:
  name: control_unit

export_include_dirs:
  - verilog

sources:
  - verilog/ctrlPkg.sv
  - verilog/instrDecoder.sv
  - verilog/controlSequencer.sv
  - verilog/controlWordGen.sv
  - verilog/controlUnit.sv
  - target: test
    files:
      - dv/clkGen.sv
      - dv/controlUnitChecker.sv
      - dv/controlUnitTb.sv

// ==== dv/clkGen.sv ====
// Testbench clock and power-on reset source; instantiated once by the testbench top
`timescale 1ns/1ps
`default_nettype none

module clkGen #(
    parameter int PeriodNs    = 100,
    parameter int ResetCycles = 5
) (
    output logic clk,
    output logic rstN
);
    initial begin
        clk = 1'b0;
        forever #(PeriodNs / 2) clk = ~clk;
    end

    // Release lands on a falling edge
    initial begin
        rstN = 1'b0;
        repeat (ResetCycles) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;
    end

endmodule

`default_nettype wire

// ==== dv/controlUnitChecker.sv ====
// Concurrent assertions on the registered control word; bound into the control unit top level
`timescale 1ns/1ps
`default_nettype none

module controlUnitChecker (
    input logic               clk,
    input logic               rstN,
    input ctrlPkg::ctrlWord_t ctrl
);
    // Number of failed assertions so far
    int assertFails = 0;

    pcWriteWithIr: assert property (@(posedge clk) disable iff (!rstN)
        ctrl.pcWrite |-> ctrl.irWrite)
    else begin
        assertFails++;
        $error("pcWrite set without irWrite");
    end

    noReadAndWrite: assert property (@(posedge clk) disable iff (!rstN)
        !(ctrl.memRead && ctrl.regWrite))
    else begin
        assertFails++;
        $error("memRead and regWrite set together");
    end

    // Decode step 0 always follows the fetch that wrote the PC
    aluOutAfterPc: assert property (@(posedge clk) disable iff (!rstN)
        ctrl.pcWrite |=> ctrl.aluOutLoad)
    else begin
        assertFails++;
        $error("aluOutLoad missing one cycle after pcWrite");
    end

    loadAbSingle: assert property (@(posedge clk) disable iff (!rstN)
        ctrl.loadAb |=> !ctrl.loadAb)
    else begin
        assertFails++;
        $error("loadAb set in two consecutive cycles");
    end

endmodule

bind controlUnit controlUnitChecker checker_i (
    .clk  (clk),
    .rstN (rstN),
    .ctrl (ctrl)
);

`default_nettype wire

// ==== dv/controlUnitTb.sv ====
// Testbench top for the control unit; runs reset, ALU, unimplemented, illegal and reset tests
`timescale 1ns/1ps
`default_nettype none

`include "ctrlDefs.svh"

module controlUnitTb;
    import ctrlPkg::*;

    localparam int WaitLimit = 40;

    logic                clk;
    logic                porRstN;
    logic                tbRstN;
    logic                rstN;
    logic [`OP_W-1:0]    op;
    logic [`FUNCT_W-1:0] funct;
    ctrlWord_t           ctrl;

    int errCount   = 0;
    int checkCount = 0;
    int testNum    = 0;

    // Legal codes that have no sequence of their own
    logic [`OP_W-1:0] nopOps [16] = '{`OP_SRAM, `OP_J, `OP_JAL, `OP_BEQ, `OP_BNE, `OP_BLE,
        `OP_BGT, `OP_ADDIU, `OP_SLTI, `OP_LUI, `OP_LB, `OP_LH, `OP_LW, `OP_SB, `OP_SH, `OP_RT};
    logic [`FUNCT_W-1:0] nopFuncts [15] = '{`FUNCT_SLL, `FUNCT_SRL, `FUNCT_SRA, `FUNCT_SLLV,
        `FUNCT_DIVM, `FUNCT_SRAV, `FUNCT_JR, `FUNCT_BREAK, `FUNCT_MFHI, `FUNCT_MFLO,
        `FUNCT_RTE, `FUNCT_MULT, `FUNCT_DIV, `FUNCT_AND, `FUNCT_SLT};

    assign rstN = porRstN & tbRstN;

    clkGen #(.PeriodNs(100), .ResetCycles(5)) clkGen_i (.clk(clk), .rstN(porRstN));

    controlUnit dut_i (.clk(clk), .rstN(rstN), .op(op), .funct(funct), .ctrl(ctrl));

    function automatic instrClass_t refClass(input logic [`OP_W-1:0] opVal,
                                             input logic [`FUNCT_W-1:0] functVal);
        instrClass_t cls;
        cls = ClsIllegal;
        if (opVal == `OP_RTYPE) begin
            foreach (nopFuncts[i]) begin
                if (functVal == nopFuncts[i]) cls = ClsNop;
            end
            if (functVal == `FUNCT_ADD) cls = ClsAdd;
            if (functVal == `FUNCT_SUB) cls = ClsSub;
        end else if (opVal == `OP_ADDI) begin
            cls = ClsAddImm;
        end else begin
            foreach (nopOps[i]) begin
                if (opVal == nopOps[i]) cls = ClsNop;
            end
        end
        return cls;
    endfunction

    function automatic bit aluClass(input instrClass_t cls);
        return cls == ClsAdd || cls == ClsSub || cls == ClsAddImm;
    endfunction

    function automatic ctrlWord_t stackWord();
        ctrlWord_t w;
        w = '0;
        w.regWrite = 1'b1;
        w.wrReg    = `SP_REG_SEL;
        w.wdReg    = `SP_DATA_SEL;
        return w;
    endfunction

    function automatic ctrlWord_t fetchWord(input int s);
        ctrlWord_t w;
        w = '0;
        if (s == `FETCH_STEPS - 1) begin
            w.pcWrite = 1'b1;
            w.irWrite = 1'b1;
        end else begin
            w.memRead = 1'b1;
            w.aluSrcB = 2'd1;
            w.aluOp   = 3'd1;
        end
        return w;
    endfunction

    // Expected word idx cycles after a pcWrite pulse
    function automatic ctrlWord_t refWord(input instrClass_t cls, input int idx);
        ctrlWord_t w;
        bit alu;
        int len;
        w   = '0;
        alu = aluClass(cls);
        len = alu ? 9 : 7;
        if (idx == 1) begin
            w.aluSrcB    = 2'd3;
            w.aluOp      = 3'd1;
            w.aluOutLoad = 1'b1;
        end else if (idx == 2) begin
            w.loadAb = 1'b1;
        end else if (alu && idx == 3) begin
            w.aluSrcA    = 2'd2;
            w.aluOutLoad = 1'b1;
            // Operand select and ALU operation per class
            case (cls)
                ClsAdd: begin
                    w.aluSrcB = 2'd0;
                    w.aluOp   = 3'd1;
                end
                ClsSub: begin
                    w.aluSrcB = 2'd0;
                    w.aluOp   = 3'd2;
                end
                default: begin
                    w.aluSrcB = 2'd2;
                    w.aluOp   = 3'd1;
                end
            endcase
        end else if (alu && idx == 4) begin
            w.regWrite = 1'b1;
            w.wrReg    = 2'd1;
        end else if (idx >= len - 3 && idx <= len) begin
            w = fetchWord(idx - (len - 3));
        end
        return w;
    endfunction

    function automatic logic [`OP_W-1:0] unknownOp();
        logic [`OP_W-1:0] val;
        val = 6'b111111;
        for (int i = 0; i < 64; i++) begin
            val = `OP_W'($urandom);
            if (refClass(val, '0) == ClsIllegal) break;
        end
        return (refClass(val, '0) == ClsIllegal) ? val : 6'b111111;
    endfunction

    function automatic logic [`FUNCT_W-1:0] unknownFunct();
        logic [`FUNCT_W-1:0] val;
        val = 6'b111111;
        for (int i = 0; i < 64; i++) begin
            val = `FUNCT_W'($urandom);
            if (refClass(`OP_RTYPE, val) == ClsIllegal) break;
        end
        return (refClass(`OP_RTYPE, val) == ClsIllegal) ? val : 6'b111111;
    endfunction

    task automatic checkWord(input ctrlWord_t got, input ctrlWord_t exp, input string what);
        checkCount++;
        if (got !== exp) begin
            errCount++;
            $display("Fail at %0d ns: %s, ctrl %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic checkCycles(input int got, input int exp, input string what);
        checkCount++;
        if (got != exp) begin
            errCount++;
            $display("Fail at %0d ns: %s, %0d cycles between pcWrite pulses, expected %0d",
                     $time, what, got, exp);
        end
    endtask

    task automatic stopOnTimeout(input string what);
        errCount++;
        $display("Timeout: %s", what);
        $display("Checks failed");
        $finish;
    endtask

    task automatic reportTest(input string tag, input int errBefore);
        testNum++;
        $display("Test %0d %s: %s", testNum, tag, (errCount == errBefore) ? "ok" : "FAILED");
    endtask

    // Ends on the falling edge that shows the first pcWrite
    task automatic checkStartup(input string name);
        int n;
        int s;
        int errBefore;
        errBefore = errCount;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!rstN && n < WaitLimit);
        if (!rstN) begin
            stopOnTimeout("reset was never released");
        end else begin
            @(negedge clk);
            checkWord(ctrl, stackWord(), {name, " stack word"});
            for (s = 0; s < `FETCH_STEPS; s++) begin
                @(negedge clk);
                checkWord(ctrl, fetchWord(s), $sformatf("%s fetch step %0d", name, s));
            end
            reportTest(name, errBefore);
        end
    endtask

    // Starts and ends on a falling edge that shows pcWrite
    task automatic runInstr(input logic [`OP_W-1:0] opVal, input logic [`FUNCT_W-1:0] functVal,
                            input string name);
        instrClass_t cls;
        int expLen;
        int idx;
        int errBefore;
        string tag;
        errBefore = errCount;
        tag    = $sformatf("%s op=%h funct=%h", name, opVal, functVal);
        cls    = refClass(opVal, functVal);
        expLen = aluClass(cls) ? 9 : 7;
        op     = opVal;
        funct  = functVal;
        idx    = 0;
        do begin
            @(negedge clk);
            idx++;
            checkWord(ctrl, refWord(cls, idx), $sformatf("%s cycle %0d", tag, idx));
        end while (!ctrl.pcWrite && idx < WaitLimit);
        if (!ctrl.pcWrite) begin
            stopOnTimeout($sformatf("%s: no pcWrite pulse within %0d cycles", tag, WaitLimit));
        end else begin
            checkCycles(idx, expLen, tag);
            reportTest(tag, errBefore);
        end
    endtask

    task automatic resetMidRun(input string name);
        int errBefore;
        errBefore = errCount;
        op    = `OP_RTYPE;
        funct = `FUNCT_ADD;
        // Into execute step 0 of the add
        repeat (3) @(negedge clk);
        checkWord(ctrl, refWord(ClsAdd, 3), {name, " execute word before reset"});
        tbRstN = 1'b0;
        #1;
        checkWord(ctrl, '0, {name, " ctrl cleared"});
        repeat (2) @(negedge clk);
        tbRstN = 1'b1;
        reportTest(name, errBefore);
    endtask

    initial begin
        int assertCount;
        void'($urandom(61711));
        tbRstN = 1'b1;
        op     = '0;
        funct  = '0;

        checkStartup("reset sequence");
        runInstr(`OP_RTYPE, `FUNCT_ADD, "add");
        runInstr(`OP_RTYPE, `FUNCT_SUB, "sub");
        runInstr(`OP_ADDI, `FUNCT_W'($urandom), "addi");
        repeat (6) begin
            runInstr(`OP_RTYPE, nopFuncts[$urandom_range(14)], "unimplemented R-type");
            runInstr(nopOps[$urandom_range(15)], `FUNCT_W'($urandom), "unimplemented imm");
        end
        repeat (5) begin
            runInstr(unknownOp(), `FUNCT_W'($urandom), "unknown opcode");
            runInstr(`OP_RTYPE, unknownFunct(), "unknown funct");
        end
        resetMidRun("reset during execute");
        checkStartup("restart after reset");
        runInstr(`OP_RTYPE, `FUNCT_ADD, "add after restart");

        assertCount = dut_i.checker_i.assertFails;
        $display("Summary: %0d tests, %0d checks, %0d errors, %0d assertion failures",
                 testNum, checkCount, errCount, assertCount);
        if (errCount == 0 && assertCount == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+verilog
verilog/ctrlPkg.sv
verilog/instrDecoder.sv
verilog/controlSequencer.sv
verilog/controlWordGen.sv
verilog/controlUnit.sv
dv/clkGen.sv
dv/controlUnitChecker.sv
dv/controlUnitTb.sv

// ==== verilog/controlSequencer.sv ====
// Phase and step state of the microsequencer; dispatches on the instruction class after decode
`timescale 1ns/1ps
`default_nettype none

`include "ctrlDefs.svh"

module controlSequencer (
    input  logic                 clk,
    input  logic                 rstN,
    input  ctrlPkg::instrClass_t instrClass,
    output ctrlPkg::phase_t      phase,
    output logic [`STEP_W-1:0]   step
);
    import ctrlPkg::*;

    localparam logic [`STEP_W-1:0] FetchLast  = `STEP_W'(`FETCH_STEPS - 1);
    localparam logic [`STEP_W-1:0] DecodeLast = `STEP_W'(`DECODE_STEPS - 1);
    localparam logic [`STEP_W-1:0] AluLast    = `STEP_W'(`ALU_STEPS - 1);

    // Execute length is fixed at dispatch
    logic aluInstr;
    logic isAluClass;

    assign isAluClass = (instrClass == ClsAdd) || (instrClass == ClsSub) ||
                        (instrClass == ClsAddImm);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            phase    <= PhReset;
            step     <= '0;
            aluInstr <= 1'b0;
        end else begin
            case (phase)
                PhReset: begin
                    phase <= PhFetch;
                    step  <= '0;
                end
                PhFetch: begin
                    if (step == FetchLast) begin
                        phase <= PhDecode;
                        step  <= '0;
                    end else begin
                        step <= step + 1'b1;
                    end
                end
                PhDecode: begin
                    if (step == DecodeLast) begin
                        // Dispatch edge
                        aluInstr <= isAluClass;
                        phase    <= (instrClass == ClsIllegal) ? PhTrap : PhExecute;
                        step     <= '0;
                    end else begin
                        step <= step + 1'b1;
                    end
                end
                PhExecute: begin
                    if (!aluInstr || step == AluLast) begin
                        phase <= PhFetch;
                        step  <= '0;
                    end else begin
                        step <= step + 1'b1;
                    end
                end
                default: begin
                    // Trap and unused encodings go straight back to fetch
                    phase <= PhFetch;
                    step  <= '0;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== verilog/controlUnit.sv ====
// Top level of the multicycle control unit; connects decoder, sequencer and word generator
`timescale 1ns/1ps
`default_nettype none

`include "ctrlDefs.svh"

module controlUnit (
    input  logic                clk,
    input  logic                rstN,
    input  logic [`OP_W-1:0]    op,
    input  logic [`FUNCT_W-1:0] funct,
    output ctrlPkg::ctrlWord_t  ctrl
);
    import ctrlPkg::*;

    instrClass_t         instrClass;
    phase_t              phase;
    logic [`STEP_W-1:0]  step;

    instrDecoder decoder_i (
        .op         (op),
        .funct      (funct),
        .instrClass (instrClass)
    );

    controlSequencer sequencer_i (
        .clk        (clk),
        .rstN       (rstN),
        .instrClass (instrClass),
        .phase      (phase),
        .step       (step)
    );

    // Output register lags the sequencer by one edge
    controlWordGen wordGen_i (
        .clk        (clk),
        .rstN       (rstN),
        .phase      (phase),
        .step       (step),
        .instrClass (instrClass),
        .ctrl       (ctrl)
    );

endmodule

`default_nettype wire

// ==== verilog/controlWordGen.sv ====
// Registered control word for each phase, step and instruction class of the sequencer
`timescale 1ns/1ps
`default_nettype none

`include "ctrlDefs.svh"

module controlWordGen (
    input  logic                 clk,
    input  logic                 rstN,
    input  ctrlPkg::phase_t      phase,
    input  logic [`STEP_W-1:0]   step,
    input  ctrlPkg::instrClass_t instrClass,
    output ctrlPkg::ctrlWord_t   ctrl
);
    import ctrlPkg::*;

    localparam logic [`STEP_W-1:0] FetchLast  = `STEP_W'(`FETCH_STEPS - 1);
    localparam logic [`STEP_W-1:0] DecodeLast = `STEP_W'(`DECODE_STEPS - 1);

    instrClass_t execClass;
    ctrlWord_t   nextWord;

    // Class captured at dispatch so op and funct may change during execute
    always_ff @(posedge clk) begin
        if (phase == PhDecode && step == DecodeLast) begin
            execClass <= instrClass;
        end
    end

    always_comb begin
        nextWord = '0;
        case (phase)
            PhReset: begin
                nextWord.regWrite = 1'b1;
                nextWord.wrReg    = `SP_REG_SEL;
                nextWord.wdReg    = `SP_DATA_SEL;
            end
            PhFetch: begin
                if (step == FetchLast) begin
                    nextWord.pcWrite = 1'b1;
                    nextWord.irWrite = 1'b1;
                end else begin
                    // Memory read while PC + 4 is computed
                    nextWord.memRead = 1'b1;
                    nextWord.aluSrcB = 2'd1;
                    nextWord.aluOp   = 3'd1;
                end
            end
            PhDecode: begin
                if (step == DecodeLast) begin
                    nextWord.loadAb = 1'b1;
                end else begin
                    // Branch target precompute
                    nextWord.aluSrcB    = 2'd3;
                    nextWord.aluOp      = 3'd1;
                    nextWord.aluOutLoad = 1'b1;
                end
            end
            PhExecute: begin
                if (step == '0 && execClass inside {ClsAdd, ClsSub, ClsAddImm}) begin
                    nextWord.aluSrcA    = 2'd2;
                    nextWord.aluOutLoad = 1'b1;
                    nextWord.aluSrcB    = (execClass == ClsAddImm) ? 2'd2 : 2'd0;
                    nextWord.aluOp      = (execClass == ClsSub) ? 3'd2 : 3'd1;
                end else if (step == 2'd1) begin
                    // Write back ALUOut
                    nextWord.regWrite = 1'b1;
                    nextWord.wrReg    = 2'd1;
                    nextWord.wdReg    = 3'd0;
                end
            end
            default: nextWord = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            ctrl <= '0;
        end else begin
            ctrl <= nextWord;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/ctrlDefs.svh ====
// Opcode, function code, width and step-count macros shared by the control unit package and RTL
`ifndef CTRL_DEFS_SVH
`define CTRL_DEFS_SVH

// Instruction field and sequencer widths
`define OP_W            6
`define FUNCT_W         6
`define STEP_W          2
`define SEL_W           2
`define WSEL_W          3

// Steps per phase
`define FETCH_STEPS     4
`define DECODE_STEPS    2
`define ALU_STEPS       3

// Opcodes
`define OP_RTYPE        6'b000000
`define OP_SRAM         6'b000001
`define OP_J            6'b000010
`define OP_JAL          6'b000011
`define OP_BEQ          6'b000100
`define OP_BNE          6'b000101
`define OP_BLE          6'b000110
`define OP_BGT          6'b000111
`define OP_ADDI         6'b001000
`define OP_ADDIU        6'b001001
`define OP_SLTI         6'b001010
`define OP_LUI          6'b001111
`define OP_LB           6'b100000
`define OP_LH           6'b100001
`define OP_LW           6'b100011
`define OP_SB           6'b101000
`define OP_SH           6'b101001
`define OP_RT           6'b101011

// Function codes under OP_RTYPE
`define FUNCT_SLL       6'b000000
`define FUNCT_SRL       6'b000010
`define FUNCT_SRA       6'b000011
`define FUNCT_SLLV      6'b000100
`define FUNCT_DIVM      6'b000101
`define FUNCT_SRAV      6'b000111
`define FUNCT_JR        6'b001000
`define FUNCT_BREAK     6'b001101
`define FUNCT_MFHI      6'b010000
`define FUNCT_MFLO      6'b010010
`define FUNCT_RTE       6'b010011
`define FUNCT_MULT      6'b011000
`define FUNCT_DIV       6'b011010
`define FUNCT_ADD       6'b100000
`define FUNCT_SUB       6'b100010
`define FUNCT_AND       6'b100100
`define FUNCT_SLT       6'b101010

// Stack pointer write done by the reset sequence
`define SP_REG_SEL      2'b11
`define SP_DATA_SEL     3'b110

`endif

// ==== verilog/ctrlPkg.sv ====
// Control unit types; imported by the RTL and testbench that use them
`default_nettype none

`include "ctrlDefs.svh"

package ctrlPkg;

    // Result of opcode and function decode
    typedef enum logic [2:0] {
        ClsAdd,
        ClsSub,
        ClsAddImm,
        ClsNop,
        ClsIllegal
    } instrClass_t;

    // PhReset first so the reset phase encodes as zero
    typedef enum logic [2:0] {
        PhReset,
        PhFetch,
        PhDecode,
        PhExecute,
        PhTrap
    } phase_t;

    // Datapath strobes and mux selects
    typedef struct packed {
        logic              pcWrite;
        logic              loadAb;
        logic              aluOutLoad;
        logic              memRead;
        logic              irWrite;
        logic              regWrite;
        logic [`SEL_W-1:0]  aluSrcA;
        logic [`SEL_W-1:0]  aluSrcB;
        logic [`SEL_W-1:0]  wrReg;
        logic [`WSEL_W-1:0] aluOp;
        logic [`WSEL_W-1:0] wdReg;
    } ctrlWord_t;

endpackage

`default_nettype wire

// ==== verilog/instrDecoder.sv ====
// Combinational opcode and function field decode into the instruction class used by the sequencer
`timescale 1ns/1ps
`default_nettype none

`include "ctrlDefs.svh"

module instrDecoder (
    input  logic [`OP_W-1:0]    op,
    input  logic [`FUNCT_W-1:0] funct,
    output ctrlPkg::instrClass_t instrClass
);
    import ctrlPkg::*;

    always_comb begin
        instrClass = ClsIllegal;
        case (op)
            `OP_RTYPE: begin
                case (funct)
                    `FUNCT_ADD: instrClass = ClsAdd;
                    `FUNCT_SUB: instrClass = ClsSub;
                    // Legal but not sequenced yet
                    `FUNCT_AND, `FUNCT_DIV, `FUNCT_MULT, `FUNCT_JR,
                    `FUNCT_MFHI, `FUNCT_MFLO, `FUNCT_SLL, `FUNCT_SLLV,
                    `FUNCT_SLT, `FUNCT_SRA, `FUNCT_SRAV, `FUNCT_SRL,
                    `FUNCT_BREAK, `FUNCT_RTE, `FUNCT_DIVM: begin
                        instrClass = ClsNop;
                    end
                    default: instrClass = ClsIllegal;
                endcase
            end
            `OP_ADDI: instrClass = ClsAddImm;
            // Immediate and jump types without a sequence
            `OP_ADDIU,
            `OP_BEQ,
            `OP_BNE,
            `OP_BLE,
            `OP_BGT,
            `OP_SRAM,
            `OP_LB,
            `OP_LH,
            `OP_LUI,
            `OP_LW,
            `OP_SB,
            `OP_SH,
            `OP_SLTI,
            `OP_RT,
            `OP_J,
            `OP_JAL: begin
                instrClass = ClsNop;
            end
            default: instrClass = ClsIllegal;
        endcase
    end

endmodule

`default_nettype wire
